//--- hdl/debugPkg.sv
package debugPkg;

   ///////////////////////////////////////////////////////////////////////
   // Widths
   ///////////////////////////////////////////////////////////////////////

   localparam int dataWidth    = 32;                      // Processor word
   localparam int byteWidth    = 8;                       // One UART byte
   localparam int bytesPerWord = dataWidth / byteWidth;
   localparam int pcWidth      = 8;

   ///////////////////////////////////////////////////////////////////////
   // Command bytes from the host
   ///////////////////////////////////////////////////////////////////////

   localparam logic [byteWidth-1:0] cmdContinuous = "c";
   localparam logic [byteWidth-1:0] cmdStep       = "s";
   localparam logic [byteWidth-1:0] cmdNext       = "n";  // One clock in step mode

   ///////////////////////////////////////////////////////////////////////
   // States and snapshot layout
   ///////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      init,
      idle,
      continuous,
      step,
      send
   } ctrlState;

   // Snapshot is sent in this order
   typedef enum logic [1:0] {
      pcSeg,
      pipeSeg,
      regSeg,
      memSeg
   } dumpSegment;

   localparam int pipeWords = 3;  // IF/ID instr, EX/MEM ALU out, MEM/WB read data

endpackage

//--- hdl/debugControl.sv
module debugControl (
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             endOfProgram,
   // UART receive FIFO
   input  logic [debugPkg::byteWidth-1:0]   rxData,
   input  logic                             rxValid,
   output logic                             rxPop,
   // Dump handshake with the sequencer
   input  logic                             dumpDone,
   output logic                             dumpStart,
   // Processor side
   output logic                             datapathOn,
   output logic                             datapathReset,
   output logic                             ledIdle
);

   debugPkg::ctrlState state;
   debugPkg::ctrlState nextState;

   logic isContinuous;
   logic isStep;
   logic isNext;

   ///////////////////////////////////////////////////////////////////////
   // Command decode
   ///////////////////////////////////////////////////////////////////////

   assign isContinuous = (rxData == debugPkg::cmdContinuous);
   assign isStep       = (rxData == debugPkg::cmdStep);
   assign isNext       = (rxData == debugPkg::cmdNext);

   ///////////////////////////////////////////////////////////////////////
   // State register
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         state     <= debugPkg::init;
         dumpStart <= 1'b0;
      end else begin
         state     <= nextState;
         // Pulse on the first cycle spent in send
         dumpStart <= (nextState == debugPkg::send) && (state != debugPkg::send);
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Next state and outputs
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      nextState     = state;
      rxPop         = 1'b0;
      datapathOn    = 1'b0;
      datapathReset = 1'b0;
      ledIdle       = 1'b0;

      case (state)
         debugPkg::init: begin
            datapathReset = 1'b1;
            nextState     = debugPkg::idle;
         end

         debugPkg::idle: begin
            ledIdle       = 1'b1;
            datapathReset = 1'b1;        // Pipe held empty while waiting
            rxPop         = rxValid;     // Every byte is consumed, unknown ones dropped
            if (rxValid && isContinuous) begin
               nextState = debugPkg::continuous;
            end else if (rxValid && isStep) begin
               nextState = debugPkg::step;
            end
         end

         debugPkg::continuous: begin
            // Run freely and stop on the cycle the program ends
            datapathOn = !endOfProgram;
            if (endOfProgram) begin
               nextState = debugPkg::send;
            end
         end

         debugPkg::step: begin
            rxPop = rxValid;
            if (rxValid && isNext) begin
               datapathOn = 1'b1;       // Exactly one clock of the pipe
               nextState  = debugPkg::send;
            end
         end

         debugPkg::send: begin
            if (dumpDone) begin
               nextState = endOfProgram ? debugPkg::idle : debugPkg::step;
            end
         end

         default: begin
            nextState = debugPkg::init;
         end
      endcase
   end

endmodule

//--- hdl/dumpSequencer.sv
module dumpSequencer #(
   parameter int numRegs     = 32,
   parameter int numMemWords = 16
) (
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             dumpStart,
   output logic                             dumpDone,
   // Snapshot sources
   input  logic [debugPkg::pcWidth-1:0]     fetchPc,
   input  logic [debugPkg::dataWidth-1:0]   ifIdInstr,
   input  logic [debugPkg::dataWidth-1:0]   exMemAluOut,
   input  logic [debugPkg::dataWidth-1:0]   memWbReadData,
   output logic [$clog2(numRegs)-1:0]       regAddr,
   input  logic [debugPkg::dataWidth-1:0]   regData,
   output logic [$clog2(numMemWords)-1:0]   memAddr,
   input  logic [debugPkg::dataWidth-1:0]   memData,
   output logic                             debugRamSrc,
   // UART transmit side
   output logic [debugPkg::byteWidth-1:0]   txData,
   output logic                             txWrite,
   input  logic                             txDone
);

   localparam int regAddrWidth = $clog2(numRegs);
   localparam int memAddrWidth = $clog2(numMemWords);
   localparam int pipeIdxWidth = $clog2(debugPkg::pipeWords);
   localparam int addrWidth    = (regAddrWidth > memAddrWidth) ? regAddrWidth : memAddrWidth;
   localparam int idxWidth     = (addrWidth > pipeIdxWidth) ? addrWidth : pipeIdxWidth;
   localparam int byteIdxWidth = $clog2(debugPkg::bytesPerWord);

   localparam logic [byteIdxWidth-1:0] topByte = byteIdxWidth'(debugPkg::bytesPerWord - 1);

   debugPkg::dumpSegment segment;
   debugPkg::dumpSegment nextSegment;

   logic [idxWidth-1:0]               wordIdx;
   logic [byteIdxWidth-1:0]           byteIdx;      // Counts down, MSB goes first
   logic                              busy;
   logic                              lastQueued;   // Final byte is out, waiting for its txDone
   logic [idxWidth-1:0]               segLastWord;
   logic                              wordEnd;
   logic                              segEnd;
   logic                              dumpEnd;
   logic                              issue;
   logic [debugPkg::dataWidth-1:0]    curWord;
   logic [debugPkg::byteWidth-1:0]    curByte;

   assign regAddr = wordIdx[regAddrWidth-1:0];
   assign memAddr = wordIdx[memAddrWidth-1:0];

   ///////////////////////////////////////////////////////////////////////
   // Position decode
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      case (segment)
         debugPkg::pcSeg: begin
            segLastWord = '0;
            nextSegment = debugPkg::pipeSeg;
         end
         debugPkg::pipeSeg: begin
            segLastWord = idxWidth'(debugPkg::pipeWords - 1);
            nextSegment = debugPkg::regSeg;
         end
         debugPkg::regSeg: begin
            segLastWord = idxWidth'(numRegs - 1);
            nextSegment = debugPkg::memSeg;
         end
         default: begin
            segLastWord = idxWidth'(numMemWords - 1);
            nextSegment = debugPkg::pcSeg;
         end
      endcase
   end

   assign wordEnd = (byteIdx == '0);
   assign segEnd  = wordEnd && (wordIdx == segLastWord);
   assign dumpEnd = segEnd && (segment == debugPkg::memSeg);

   ///////////////////////////////////////////////////////////////////////
   // Byte select
   ///////////////////////////////////////////////////////////////////////

   always_comb begin
      case (segment)
         debugPkg::pcSeg: begin
            // PC sits in the low byte, byteIdx is 0 here
            curWord = {{(debugPkg::dataWidth - debugPkg::pcWidth){1'b0}}, fetchPc};
         end
         debugPkg::pipeSeg: begin
            if (wordIdx == '0) begin
               curWord = ifIdInstr;
            end else if (wordIdx == idxWidth'(1)) begin
               curWord = exMemAluOut;
            end else begin
               curWord = memWbReadData;
            end
         end
         debugPkg::regSeg: curWord = regData;
         default:          curWord = memData;
      endcase
   end

   assign curByte = curWord[byteIdx * debugPkg::byteWidth +: debugPkg::byteWidth];

   // Start of a dump, or next byte once the UART has taken the last one
   assign issue = (!busy && dumpStart) || (busy && txDone && !lastQueued);

   always_ff @(posedge clock) begin
      if (issue) begin
         txData <= curByte;
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Walk through the snapshot
   ///////////////////////////////////////////////////////////////////////

   always_ff @(posedge clock) begin
      if (reset) begin
         busy        <= 1'b0;
         lastQueued  <= 1'b0;
         segment     <= debugPkg::pcSeg;
         wordIdx     <= '0;
         byteIdx     <= '0;
         txWrite     <= 1'b0;
         dumpDone    <= 1'b0;
         debugRamSrc <= 1'b0;
      end else begin
         txWrite  <= issue;
         dumpDone <= 1'b0;

         if (!busy && dumpStart) begin
            busy <= 1'b1;
         end
         if (issue && segment == debugPkg::memSeg) begin
            debugRamSrc <= 1'b1;                   // Memory read port taken over
         end

         // Address holds through the txWrite cycle, then moves to the next byte
         if (txWrite) begin
            if (dumpEnd) begin
               lastQueued <= 1'b1;
            end else if (!wordEnd) begin
               byteIdx <= byteIdx - 1'b1;
            end else begin
               byteIdx <= topByte;
               if (segEnd) begin
                  wordIdx <= '0;
                  segment <= nextSegment;
               end else begin
                  wordIdx <= wordIdx + 1'b1;
               end
            end
         end

         // Last byte acknowledged, back to rest
         if (busy && txDone && lastQueued) begin
            busy        <= 1'b0;
            lastQueued  <= 1'b0;
            dumpDone    <= 1'b1;
            debugRamSrc <= 1'b0;
            segment     <= debugPkg::pcSeg;
            wordIdx     <= '0;
            byteIdx     <= '0;
         end
      end
   end

endmodule

//--- hdl/debugUnit.sv
module debugUnit #(
   parameter int numRegs     = 32,
   parameter int numMemWords = 16
) (
   input  logic                             clock,
   input  logic                             reset,
   // UART receive FIFO
   input  logic [debugPkg::byteWidth-1:0]   rxData,
   input  logic                             rxValid,
   output logic                             rxPop,
   // UART transmitter
   output logic [debugPkg::byteWidth-1:0]   txData,
   output logic                             txWrite,
   input  logic                             txDone,
   // Processor status and control
   input  logic                             endOfProgram,
   input  logic [debugPkg::pcWidth-1:0]     fetchPc,
   input  logic [debugPkg::dataWidth-1:0]   ifIdInstr,
   input  logic [debugPkg::dataWidth-1:0]   exMemAluOut,
   input  logic [debugPkg::dataWidth-1:0]   memWbReadData,
   output logic                             datapathOn,
   output logic                             datapathReset,
   output logic                             ledIdle,
   // Register file read port
   output logic [$clog2(numRegs)-1:0]       regAddr,
   input  logic [debugPkg::dataWidth-1:0]   regData,
   // Data memory read port
   output logic [$clog2(numMemWords)-1:0]   memAddr,
   input  logic [debugPkg::dataWidth-1:0]   memData,
   output logic                             debugRamSrc
);

   logic dumpStart;
   logic dumpDone;

   ///////////////////////////////////////////////////////////////////////
   // Command handling and run control
   ///////////////////////////////////////////////////////////////////////

   debugControl u_debugControl (
      .clock         (clock),
      .reset         (reset),
      .endOfProgram  (endOfProgram),
      .rxData        (rxData),
      .rxValid       (rxValid),
      .rxPop         (rxPop),
      .dumpDone      (dumpDone),
      .dumpStart     (dumpStart),
      .datapathOn    (datapathOn),
      .datapathReset (datapathReset),
      .ledIdle       (ledIdle)
   );

   ///////////////////////////////////////////////////////////////////////
   // Snapshot to UART
   ///////////////////////////////////////////////////////////////////////

   dumpSequencer #(
      .numRegs     (numRegs),
      .numMemWords (numMemWords)
   ) u_dumpSequencer (
      .clock         (clock),
      .reset         (reset),
      .dumpStart     (dumpStart),
      .dumpDone      (dumpDone),
      .fetchPc       (fetchPc),
      .ifIdInstr     (ifIdInstr),
      .exMemAluOut   (exMemAluOut),
      .memWbReadData (memWbReadData),
      .regAddr       (regAddr),
      .regData       (regData),
      .memAddr       (memAddr),
      .memData       (memData),
      .debugRamSrc   (debugRamSrc),
      .txData        (txData),
      .txWrite       (txWrite),
      .txDone        (txDone)
   );

endmodule

//--- verif/tbPipelineModel.sv
module tbPipelineModel #(
   parameter int numRegs     = 8,
   parameter int numMemWords = 4,
   parameter int endPc       = 12
) (
   input  logic                             clock,
   input  logic                             reset,
   input  logic                             datapathOn,
   input  logic                             datapathReset,
   output logic [debugPkg::pcWidth-1:0]     fetchPc,
   output logic                             endOfProgram,
   output logic [debugPkg::dataWidth-1:0]   ifIdInstr,
   output logic [debugPkg::dataWidth-1:0]   exMemAluOut,
   output logic [debugPkg::dataWidth-1:0]   memWbReadData,
   input  logic [$clog2(numRegs)-1:0]       regAddr,
   output logic [debugPkg::dataWidth-1:0]   regData,
   input  logic [$clog2(numMemWords)-1:0]   memAddr,
   output logic [debugPkg::dataWidth-1:0]   memData,
   input  logic                             txWrite,
   output logic                             txDone
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [15:0]                    lfsrState;
   logic [debugPkg::dataWidth-1:0] regFile [numRegs];
   logic [debugPkg::dataWidth-1:0] memWords [numMemWords];
   logic [2:0]                     doneDelay;
   logic [2:0]                     doneCount;     // Cycles left until txDone

   // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1, one step per bit
   function automatic logic [31:0] takeBits(input int count);
      logic [31:0] bits;
      logic        newBit;
      int          i;
      bits = '0;
      for (i = 0; i < count; i++) begin
         newBit    = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
         lfsrState = {lfsrState[14:0], newBit};
         bits      = {bits[30:0], newBit};
      end
      return bits;
   endfunction

   initial begin
      int i;
      lfsrState     = 16'd14;
      fetchPc       = '0;
      txDone        = 1'b0;
      doneCount     = '0;
      ifIdInstr     = takeBits(32);
      exMemAluOut   = takeBits(32);
      memWbReadData = takeBits(32);
      for (i = 0; i < numRegs; i++) begin
         regFile[i] = takeBits(32);
      end
      for (i = 0; i < numMemWords; i++) begin
         memWords[i] = takeBits(32);
      end
   end

   // Read ports answer in the same cycle
   assign regData      = regFile[regAddr];
   assign memData      = memWords[memAddr];
   assign endOfProgram = (fetchPc >= endPc);

   always @(posedge clock) begin
      if (reset || datapathReset) begin
         fetchPc <= '0;
      end else if (datapathOn) begin
         fetchPc <= fetchPc + 1'b1;               // One instruction per clock
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // UART transmitter, done 1 to 4 cycles after each write
   ///////////////////////////////////////////////////////////////////////

   always @(posedge clock) begin
      txDone <= 1'b0;
      if (reset) begin
         doneCount <= '0;
      end else if (txWrite) begin
         doneDelay = 3'(takeBits(2)) + 3'd1;
         if (doneDelay == 3'd1) begin
            txDone <= 1'b1;
         end else begin
            doneCount <= doneDelay - 3'd1;
         end
      end else if (doneCount != '0) begin
         doneCount <= doneCount - 3'd1;
         if (doneCount == 3'd1) begin
            txDone <= 1'b1;
         end
      end
   end

endmodule

//--- verif/tbDebugUnit.sv
module tbDebugUnit;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int numRegs     = 8;
   localparam int numMemWords = 4;
   localparam int pipeWords   = 3;
   localparam int endPc       = 12;
   localparam int dumpBytes   = 1 + 4 * pipeWords + 4 * numRegs + 4 * numMemWords;
   localparam int regStart    = 1 + 4 * pipeWords;              // First register byte
   localparam int memStart    = dumpBytes - 4 * numMemWords;   // First memory byte
   localparam int cycleLimit  = 4000;  // About 6 dumps of 61 bytes at 6 cycles each plus slack

   logic        clock, reset;
   logic [7:0]  rxData, txData;
   logic        rxValid, rxPop, txWrite, txDone;
   logic        endOfProgram, datapathOn, datapathReset, ledIdle, debugRamSrc;
   logic [7:0]  fetchPc;
   logic [31:0] ifIdInstr, exMemAluOut, memWbReadData, regData, memData;
   logic [2:0]  regAddr;
   logic [1:0]  memAddr;

   int txCount;      // Position in the current dump (dumpBytes when none is due)
   int dumpPc;
   int onCycles;
   int cycleCount;

   debugUnit #(.numRegs(numRegs), .numMemWords(numMemWords)) u_debugUnit (
      .clock(clock), .reset(reset),
      .rxData(rxData), .rxValid(rxValid), .rxPop(rxPop),
      .txData(txData), .txWrite(txWrite), .txDone(txDone),
      .endOfProgram(endOfProgram), .fetchPc(fetchPc), .ifIdInstr(ifIdInstr),
      .exMemAluOut(exMemAluOut), .memWbReadData(memWbReadData),
      .datapathOn(datapathOn), .datapathReset(datapathReset), .ledIdle(ledIdle),
      .regAddr(regAddr), .regData(regData),
      .memAddr(memAddr), .memData(memData), .debugRamSrc(debugRamSrc)
   );

   tbPipelineModel #(.numRegs(numRegs), .numMemWords(numMemWords), .endPc(endPc))
   u_pipelineModel (
      .clock(clock), .reset(reset), .datapathOn(datapathOn), .datapathReset(datapathReset),
      .fetchPc(fetchPc), .endOfProgram(endOfProgram), .ifIdInstr(ifIdInstr),
      .exMemAluOut(exMemAluOut), .memWbReadData(memWbReadData),
      .regAddr(regAddr), .regData(regData), .memAddr(memAddr), .memData(memData),
      .txWrite(txWrite), .txDone(txDone)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   ///////////////////////////////////////////////////////////////////////
   // Reference, checker and timeout
   ///////////////////////////////////////////////////////////////////////

   // Byte k of a snapshot with all words MSB first after the PC byte
   function automatic logic [7:0] expectedByte(input int k, input int pc);
      int          wordPos;
      int          bytePos;
      logic [31:0] word;
      if (k == 0) return 8'(pc);
      wordPos = (k - 1) / 4;
      bytePos = (k - 1) % 4;                         // 0 is the MSB
      if (wordPos == 0) word = ifIdInstr;
      else if (wordPos == 1) word = exMemAluOut;
      else if (wordPos == 2) word = memWbReadData;
      else if (wordPos < pipeWords + numRegs) word = u_pipelineModel.regFile[wordPos - pipeWords];
      else word = u_pipelineModel.memWords[wordPos - pipeWords - numRegs];
      return word[31 - 8 * bytePos -: 8];
   endfunction

   task automatic checkValue(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
      if (actual !== expected) begin
         $display("** Error: %s is 0x%0h, expected 0x%0h", name, actual, expected);
         $display("STATUS: FAIL");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   always @(negedge clock) begin
      if (!reset) begin
         if (datapathOn) onCycles = onCycles + 1;
         if (txWrite && txCount >= dumpBytes) begin
            $display("A byte was sent while no dump was due");
            $display("STATUS: FAIL");
            $fatal(1, "Unexpected txWrite");
         end else if (txWrite) begin
            checkValue("txData", txData, expectedByte(txCount, dumpPc));
            if (txCount >= memStart) begin
               checkValue("debugRamSrc", debugRamSrc, 1'b1);
               checkValue("memAddr", memAddr, (txCount - memStart) / 4);
            end else begin
               checkValue("debugRamSrc", debugRamSrc, 1'b0);
               if (txCount >= regStart) begin
                  checkValue("regAddr", regAddr, (txCount - regStart) / 4);
               end
            end
            txCount = txCount + 1;
         end
      end
   end

   always @(posedge clock) begin
      cycleCount = cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
         $display("Timeout, the run did not finish within %0d cycles", cycleLimit);
         $display("STATUS: FAIL");
         $fatal(1, "Timeout");
      end
   end

   ///////////////////////////////////////////////////////////////////////
   // Stimulus
   ///////////////////////////////////////////////////////////////////////

   task automatic applyReset();
      reset = 1'b1;
      repeat (2) @(posedge clock);
      #1;
      reset    = 1'b0;
      txCount  = dumpBytes;
      onCycles = 0;
   endtask

   // Hold the byte until the FIFO pop is seen
   task automatic sendCommand(input logic [7:0] cmd);
      @(posedge clock);
      #1;
      rxData  = cmd;
      rxValid = 1'b1;
      @(negedge clock);
      while (!rxPop) @(negedge clock);
      @(posedge clock);
      #1;
      rxValid = 1'b0;
      rxData  = '0;
   endtask

   task automatic armDump(input int pc);
      @(posedge clock);
      #1;
      txCount = 0;
      dumpPc  = pc;
   endtask

   task automatic waitDumpComplete();
      do @(posedge clock); while (txCount < dumpBytes);
   endtask

   task automatic waitIdle();
      do @(negedge clock); while (!ledIdle);
   endtask

   task automatic runStep(input int pc);
      armDump(pc);
      sendCommand("n");
      waitDumpComplete();
      repeat (8) @(posedge clock);                   // Quiet line until the next command
      #1;
   endtask

   initial begin
      rxData     = '0;
      rxValid    = 1'b0;
      dumpPc     = 0;
      cycleCount = 0;
      applyReset();
      @(negedge clock);                              // Still in init
      checkValue("datapathReset", datapathReset, 1'b1);
      checkValue("ledIdle", ledIdle, 1'b0);
      checkValue("txWrite", txWrite, 1'b0);
      checkValue("rxPop", rxPop, 1'b0);
      checkValue("datapathOn", datapathOn, 1'b0);
      @(negedge clock);
      checkValue("ledIdle", ledIdle, 1'b1);
      checkValue("datapathReset", datapathReset, 1'b1);

      sendCommand("x");                              // Unknown byte in idle
      repeat (8) @(posedge clock);
      checkValue("datapathOn cycles", onCycles, 0);
      @(negedge clock);
      checkValue("ledIdle", ledIdle, 1'b1);

      sendCommand("s");
      repeat (4) @(posedge clock);
      checkValue("datapathOn cycles", onCycles, 0);
      runStep(1);
      checkValue("datapathOn cycles", onCycles, 1);

      sendCommand("q");                              // Ignored in step mode
      repeat (6) @(posedge clock);
      checkValue("datapathOn cycles", onCycles, 1);
      for (int pc = 2; pc <= 4; pc++) begin
         runStep(pc);
      end
      checkValue("datapathOn cycles", onCycles, 4);

      // Back to idle and run to the end of the program
      applyReset();
      waitIdle();
      armDump(endPc);
      sendCommand("c");
      waitDumpComplete();
      waitIdle();
      checkValue("datapathOn cycles", onCycles, endPc);

      $display("STATUS: PASS");
      $finish;
   end

endmodule

//--- build.f
hdl/debugPkg.sv
hdl/debugControl.sv
hdl/dumpSequencer.sv
hdl/debugUnit.sv
verif/tbPipelineModel.sv
verif/tbDebugUnit.sv

//--- Bender.yml
package:
  name: debug_unit

sources:
  - hdl/debugPkg.sv
  - hdl/debugControl.sv
  - hdl/dumpSequencer.sv
  - hdl/debugUnit.sv
  - target: test
    files:
      - verif/tbPipelineModel.sv
      - verif/tbDebugUnit.sv
